// File: rtl/mips_pkg.sv
// MIPS pipeline shared definitions
`default_nettype none

package mips_pkg;

   // datapath widths
   localparam int WORD_W  = 32;
   localparam int WADDR_W = 30;
   localparam int REG_W   = 5;

   // first fetch address after reset
   localparam logic [WORD_W-1:0] TEXT_START = 32'h0040_0000;

   localparam logic [REG_W-1:0] REG_LINK = 5'd31;
   localparam logic [REG_W-1:0] REG_ZERO = 5'd0;

   // one instruction word, read through whichever format the opcode implies
   typedef union packed {
      struct packed {
         logic [5:0]       op;
         logic [REG_W-1:0] rs;
         logic [REG_W-1:0] rt;
         logic [REG_W-1:0] rd;
         logic [4:0]       shamt;
         logic [5:0]       funct;
      } r;
      struct packed {
         logic [5:0]       op;
         logic [REG_W-1:0] rs;
         logic [REG_W-1:0] rt;
         logic [15:0]      imm16;
      } i;
      struct packed {
         logic [5:0]  op;
         logic [25:0] target;
      } j;
   } instr_u;

   // primary opcodes
   localparam logic [5:0] OP_SPECIAL = 6'h00;
   localparam logic [5:0] OP_ADDIU   = 6'h09;
   localparam logic [5:0] OP_SLTI    = 6'h0a;
   localparam logic [5:0] OP_SLTIU   = 6'h0b;
   localparam logic [5:0] OP_ANDI    = 6'h0c;
   localparam logic [5:0] OP_ORI     = 6'h0d;
   localparam logic [5:0] OP_XORI    = 6'h0e;
   localparam logic [5:0] OP_LUI     = 6'h0f;
   localparam logic [5:0] OP_LB      = 6'h20;
   localparam logic [5:0] OP_LH      = 6'h21;
   localparam logic [5:0] OP_LW      = 6'h23;
   localparam logic [5:0] OP_LBU     = 6'h24;
   localparam logic [5:0] OP_LHU     = 6'h25;
   localparam logic [5:0] OP_SB      = 6'h28;
   localparam logic [5:0] OP_SH      = 6'h29;
   localparam logic [5:0] OP_SW      = 6'h2b;

   // function codes under OP_SPECIAL
   localparam logic [5:0] FN_SLL     = 6'h00;
   localparam logic [5:0] FN_SRL     = 6'h02;
   localparam logic [5:0] FN_SRA     = 6'h03;
   localparam logic [5:0] FN_SLLV    = 6'h04;
   localparam logic [5:0] FN_SRLV    = 6'h06;
   localparam logic [5:0] FN_SRAV    = 6'h07;
   localparam logic [5:0] FN_SYSCALL = 6'h0c;
   localparam logic [5:0] FN_ADD     = 6'h20;
   localparam logic [5:0] FN_ADDU    = 6'h21;
   localparam logic [5:0] FN_SUB     = 6'h22;
   localparam logic [5:0] FN_SUBU    = 6'h23;
   localparam logic [5:0] FN_AND     = 6'h24;
   localparam logic [5:0] FN_OR      = 6'h25;
   localparam logic [5:0] FN_XOR     = 6'h26;
   localparam logic [5:0] FN_NOR     = 6'h27;
   localparam logic [5:0] FN_SLT     = 6'h2a;
   localparam logic [5:0] FN_SLTU    = 6'h2b;

   // ALU operations
   localparam int ALU_SEL_W = 4;
   localparam logic [ALU_SEL_W-1:0] ALU_ADD  = 4'd0;
   localparam logic [ALU_SEL_W-1:0] ALU_SUB  = 4'd1;
   localparam logic [ALU_SEL_W-1:0] ALU_AND  = 4'd2;
   localparam logic [ALU_SEL_W-1:0] ALU_OR   = 4'd3;
   localparam logic [ALU_SEL_W-1:0] ALU_XOR  = 4'd4;
   localparam logic [ALU_SEL_W-1:0] ALU_NOR  = 4'd5;
   localparam logic [ALU_SEL_W-1:0] ALU_SLT  = 4'd6;
   localparam logic [ALU_SEL_W-1:0] ALU_SLTU = 4'd7;
   localparam logic [ALU_SEL_W-1:0] ALU_SLL  = 4'd8;
   localparam logic [ALU_SEL_W-1:0] ALU_SRL  = 4'd9;
   localparam logic [ALU_SEL_W-1:0] ALU_SRA  = 4'd10;
   localparam logic [ALU_SEL_W-1:0] ALU_SLLV = 4'd11;
   localparam logic [ALU_SEL_W-1:0] ALU_SRLV = 4'd12;
   localparam logic [ALU_SEL_W-1:0] ALU_SRAV = 4'd13;

   // load result selectors, lui included
   localparam int LD_SEL_W = 3;
   localparam logic [LD_SEL_W-1:0] LD_LB  = 3'd0;
   localparam logic [LD_SEL_W-1:0] LD_LBU = 3'd1;
   localparam logic [LD_SEL_W-1:0] LD_LH  = 3'd2;
   localparam logic [LD_SEL_W-1:0] LD_LHU = 3'd3;
   localparam logic [LD_SEL_W-1:0] LD_LW  = 3'd4;
   localparam logic [LD_SEL_W-1:0] LD_LUI = 3'd5;

   // store size selectors
   localparam int ST_SEL_W = 2;
   localparam logic [ST_SEL_W-1:0] ST_SB = 2'd0;
   localparam logic [ST_SEL_W-1:0] ST_SH = 2'd1;
   localparam logic [ST_SEL_W-1:0] ST_SW = 2'd2;

endpackage

`default_nettype wire

// File: rtl/mips_decode.sv
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
   input  mips_pkg::instr_u               instr,
   output logic [mips_pkg::REG_W-1:0]     src_rs,
   output logic [mips_pkg::REG_W-1:0]     src_rt,
   output logic [mips_pkg::REG_W-1:0]     dest_reg,
   output logic                           reads_rt,
   output logic                           reg_we,
   output logic                           use_imm,
   output logic                           is_store,
   output logic                           is_load,
   output logic                           is_sys,
   output logic [mips_pkg::ALU_SEL_W-1:0] alu_sel,
   output logic [mips_pkg::LD_SEL_W-1:0]  ld_sel,
   output logic [mips_pkg::ST_SEL_W-1:0]  st_sel,
   output logic [3:0]                     mem_mask,
   output logic [mips_pkg::WORD_W-1:0]    imm
);
   import mips_pkg::*;

   logic sign_ext;
   logic rd_dest;

   // rs and rt sit in the same bits for every format
   assign src_rs = instr.i.rs;
   assign src_rt = instr.i.rt;

   always_comb begin
      // defaults describe a bubble
      reg_we   = 1'b0;
      reads_rt = 1'b0;
      use_imm  = 1'b1;
      is_store = 1'b0;
      is_load  = 1'b0;
      is_sys   = 1'b0;
      sign_ext = 1'b1;
      rd_dest  = 1'b0;
      alu_sel  = ALU_ADD;
      ld_sel   = LD_LW;
      st_sel   = ST_SW;
      case (instr.r.op)
         OP_SPECIAL: begin
            use_imm  = 1'b0;
            sign_ext = 1'b0;
            rd_dest  = 1'b1;
            reads_rt = 1'b1;
            reg_we   = 1'b1;
            case (instr.r.funct)
               FN_ADD, FN_ADDU: alu_sel = ALU_ADD;
               FN_SUB, FN_SUBU: alu_sel = ALU_SUB;
               FN_AND:          alu_sel = ALU_AND;
               FN_OR:           alu_sel = ALU_OR;
               FN_XOR:          alu_sel = ALU_XOR;
               FN_NOR:          alu_sel = ALU_NOR;
               FN_SLT:          alu_sel = ALU_SLT;
               FN_SLTU:         alu_sel = ALU_SLTU;
               FN_SLL:          alu_sel = ALU_SLL;
               FN_SRL:          alu_sel = ALU_SRL;
               FN_SRA:          alu_sel = ALU_SRA;
               FN_SLLV:         alu_sel = ALU_SLLV;
               FN_SRLV:         alu_sel = ALU_SRLV;
               FN_SRAV:         alu_sel = ALU_SRAV;
               default: begin
                  // syscall writes nothing, any other funct is a bubble
                  reg_we   = 1'b0;
                  reads_rt = 1'b0;
                  is_sys   = (instr.r.funct == FN_SYSCALL);
               end
            endcase
         end
         OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
            reg_we   = 1'b1;
            // logical immediates zero extend, arithmetic and compares sign extend
            sign_ext = (instr.i.op inside {OP_ADDIU, OP_SLTI, OP_SLTIU});
            case (instr.i.op)
               OP_SLTI:  alu_sel = ALU_SLT;
               OP_SLTIU: alu_sel = ALU_SLTU;
               OP_ANDI:  alu_sel = ALU_AND;
               OP_ORI:   alu_sel = ALU_OR;
               OP_XORI:  alu_sel = ALU_XOR;
               default:  alu_sel = ALU_ADD;
            endcase
         end
         OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LUI: begin
            reg_we  = 1'b1;
            // lui returns through the load path with its immediate
            is_load = 1'b1;
            case (instr.i.op)
               OP_LB:   ld_sel = LD_LB;
               OP_LBU:  ld_sel = LD_LBU;
               OP_LH:   ld_sel = LD_LH;
               OP_LHU:  ld_sel = LD_LHU;
               OP_LUI:  ld_sel = LD_LUI;
               default: ld_sel = LD_LW;
            endcase
         end
         OP_SB, OP_SH, OP_SW: begin
            is_store = 1'b1;
            // rt carries the store data
            reads_rt = 1'b1;
            case (instr.i.op)
               OP_SB:   st_sel = ST_SB;
               OP_SH:   st_sel = ST_SH;
               default: st_sel = ST_SW;
            endcase
         end
         // unsupported opcodes fall through as a bubble
         default: ;
      endcase
   end

   // lane mask before alignment, lowest lanes first
   assign mem_mask = !is_store          ? 4'b0000 :
                     (st_sel == ST_SB)  ? 4'b0001 :
                     (st_sel == ST_SH)  ? 4'b0011 : 4'b1111;

   // R-type keeps imm16 zero extended so shamt stays at bits 10:6
   assign imm = sign_ext ? {{16{instr.i.imm16[15]}}, instr.i.imm16}
                         : {16'h0000, instr.i.imm16};

   // non-writers name $zero so no later stage can match them
   assign dest_reg = !reg_we ? REG_ZERO :
                     rd_dest ? instr.r.rd : instr.i.rt;

endmodule

`default_nettype wire

// File: rtl/mips_hazard.sv
// Read-after-write interlock
`timescale 1ns/1ps
`default_nettype none

module mips_hazard (
   input  logic                       clk,
   input  logic                       rst_b,
   input  logic [mips_pkg::REG_W-1:0] src_rs,
   input  logic [mips_pkg::REG_W-1:0] src_rt,
   input  logic                       reads_rt,
   input  logic [mips_pkg::REG_W-1:0] dest_ex,
   input  logic [mips_pkg::REG_W-1:0] dest_mem,
   input  logic [mips_pkg::REG_W-1:0] dest_wb,
   input  logic                       we_ex,
   input  logic                       we_mem,
   input  logic                       we_wb,
   output logic                       stall_hold
);
   import mips_pkg::*;

   logic       rs_live;
   logic       rt_live;
   logic       hit_ex;
   logic       hit_mem;
   logic       hit_wb;
   logic [1:0] count;

   // $zero never carries a dependence
   assign rs_live = (src_rs != REG_ZERO);
   assign rt_live = reads_rt && (src_rt != REG_ZERO);

   assign hit_ex  = we_ex  && ((rs_live && src_rs == dest_ex)  || (rt_live && src_rt == dest_ex));
   assign hit_mem = we_mem && ((rs_live && src_rs == dest_mem) || (rt_live && src_rt == dest_mem));
   assign hit_wb  = we_wb  && ((rs_live && src_rs == dest_wb)  || (rt_live && src_rt == dest_wb));

   // countdown covers the cycles after the detecting one
   // nearest producer wins, a writeback hit needs no extra cycle
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         count <= 2'd0;
      end else if (count != 2'd0) begin
         count <= count - 2'd1;
      end else if (hit_ex) begin
         count <= 2'd2;
      end else if (hit_mem) begin
         count <= 2'd1;
      end
   end

   assign stall_hold = (count != 2'd0) || hit_ex || hit_mem || hit_wb;

endmodule

`default_nettype wire

// File: rtl/mips_regfile.sv
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
   input  logic                        clk,
   input  logic                        rst_b,
   input  logic [mips_pkg::REG_W-1:0]  rd_a,
   input  logic [mips_pkg::REG_W-1:0]  rd_b,
   input  logic [mips_pkg::REG_W-1:0]  wr_addr,
   input  logic                        wr_en,
   input  logic [mips_pkg::WORD_W-1:0] wr_data,
   output logic [mips_pkg::WORD_W-1:0] rdata_a,
   output logic [mips_pkg::WORD_W-1:0] rdata_b
);
   import mips_pkg::*;

   logic [WORD_W-1:0] regs [2**REG_W];
   logic              wr_live;

   // writes to $zero are dropped, so it reads zero forever
   assign wr_live = wr_en && (wr_addr != REG_ZERO);

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 2**REG_W; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_live) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // write-through, decode sees the writeback value in the same cycle
   assign rdata_a = (wr_live && wr_addr == rd_a) ? wr_data : regs[rd_a];
   assign rdata_b = (wr_live && wr_addr == rd_b) ? wr_data : regs[rd_b];

endmodule

`default_nettype wire

// File: rtl/mips_alu.sv
// Integer ALU
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
   input  logic [mips_pkg::WORD_W-1:0]    op_a,
   input  logic [mips_pkg::WORD_W-1:0]    op_b,
   input  logic [mips_pkg::ALU_SEL_W-1:0] alu_sel,
   input  logic [4:0]                     shamt,
   output logic [mips_pkg::WORD_W-1:0]    result
);
   import mips_pkg::*;

   logic [4:0] var_amt;

   // variable shifts take the amount from rs
   assign var_amt = op_a[4:0];

   always_comb begin
      case (alu_sel)
         ALU_ADD:  result = op_a + op_b;
         ALU_SUB:  result = op_a - op_b;
         ALU_AND:  result = op_a & op_b;
         ALU_OR:   result = op_a | op_b;
         ALU_XOR:  result = op_a ^ op_b;
         ALU_NOR:  result = ~(op_a | op_b);
         ALU_SLT:  result = {{(WORD_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         ALU_SLTU: result = {{(WORD_W-1){1'b0}}, op_a < op_b};
         // shifts move rt, which arrives on op_b
         ALU_SLL:  result = op_b << shamt;
         ALU_SRL:  result = op_b >> shamt;
         ALU_SRA:  result = $signed(op_b) >>> shamt;
         ALU_SLLV: result = op_b << var_amt;
         ALU_SRLV: result = op_b >> var_amt;
         ALU_SRAV: result = $signed(op_b) >>> var_amt;
         default:  result = op_a + op_b;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/mips_mem_align.sv
// Load and store lane alignment
`timescale 1ns/1ps
`default_nettype none

module mips_mem_align (
   input  logic [1:0]                    addr_lo,
   input  logic [mips_pkg::ST_SEL_W-1:0] st_sel,
   input  logic [3:0]                    mem_mask,
   input  logic [mips_pkg::WORD_W-1:0]   store_src,
   input  logic [mips_pkg::LD_SEL_W-1:0] ld_sel,
   input  logic [mips_pkg::WORD_W-1:0]   mem_word,
   input  logic [15:0]                   imm_hi,
   output logic [mips_pkg::WORD_W-1:0]   store_data,
   output logic [3:0]                    write_mask,
   output logic [mips_pkg::WORD_W-1:0]   load_data
);
   import mips_pkg::*;

   logic [4:0]        bit_off;
   logic [WORD_W-1:0] lane_word;

   // little endian, byte offset n lands in lane n
   assign bit_off = {addr_lo, 3'b000};

   always_comb begin
      case (st_sel)
         ST_SB:   store_data = {24'h000000, store_src[7:0]} << bit_off;
         ST_SH:   store_data = {16'h0000, store_src[15:0]} << bit_off;
         default: store_data = store_src;
      endcase
   end

   // aligned words have addr_lo of zero and keep the full mask
   assign write_mask = mem_mask << addr_lo;

   // addressed byte or halfword brought down to the bottom
   assign lane_word = mem_word >> bit_off;

   always_comb begin
      case (ld_sel)
         LD_LB:   load_data = {{24{lane_word[7]}}, lane_word[7:0]};
         LD_LBU:  load_data = {24'h000000, lane_word[7:0]};
         LD_LH:   load_data = {{16{lane_word[15]}}, lane_word[15:0]};
         LD_LHU:  load_data = {16'h0000, lane_word[15:0]};
         LD_LUI:  load_data = {imm_hi, 16'h0000};
         // lw takes the word as read
         default: load_data = mem_word;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/mips_core.sv
// Five-stage MIPS integer pipeline
`timescale 1ns/1ps
`default_nettype none

module mips_core (
   input  logic                         clk,
   input  logic                         rst_b,
   input  logic [mips_pkg::WORD_W-1:0]  inst,
   input  logic [mips_pkg::WORD_W-1:0]  mem_data_out,
   output logic [mips_pkg::WADDR_W-1:0] inst_addr,
   output logic [mips_pkg::WADDR_W-1:0] mem_addr,
   output logic [mips_pkg::WORD_W-1:0]  mem_data_in,
   output logic [3:0]                   mem_write_en,
   output logic                         halted
);
   import mips_pkg::*;

   // fetch and decode
   logic [WORD_W-1:0]    pc;
   instr_u               instr_d;
   logic                 stall_hold;
   logic                 hold_front;
   logic [REG_W-1:0]     src_rs, src_rt, dest_d;
   logic                 reads_rt_d, reg_we_d, use_imm_d;
   logic                 is_store_d, is_load_d, is_sys_d;
   logic [ALU_SEL_W-1:0] alu_sel_d;
   logic [LD_SEL_W-1:0]  ld_sel_d;
   logic [ST_SEL_W-1:0]  st_sel_d;
   logic [3:0]           mem_mask_d;
   logic [WORD_W-1:0]    imm_d, rs_data_d, rt_data_d;

   // execute
   logic                 reg_we_ex, use_imm_ex, is_store_ex, is_load_ex, is_sys_ex;
   logic [ALU_SEL_W-1:0] alu_sel_ex;
   logic [LD_SEL_W-1:0]  ld_sel_ex;
   logic [ST_SEL_W-1:0]  st_sel_ex;
   logic [3:0]           mem_mask_ex;
   logic [REG_W-1:0]     dest_ex;
   logic [WORD_W-1:0]    rs_data_ex, rt_data_ex, imm_ex, alu_b, alu_out;

   // memory
   logic                 reg_we_mem, is_store_mem, is_load_mem, is_sys_mem;
   logic [LD_SEL_W-1:0]  ld_sel_mem;
   logic [ST_SEL_W-1:0]  st_sel_mem;
   logic [3:0]           mem_mask_mem, write_mask;
   logic [REG_W-1:0]     dest_mem;
   logic [WORD_W-1:0]    alu_mem, rt_mem, load_data;
   logic [15:0]          imm_hi_mem;

   // writeback
   logic                 reg_we_wb, is_load_wb, is_sys_wb;
   logic [REG_W-1:0]     dest_wb;
   logic [WORD_W-1:0]    alu_wb, load_wb, wr_data;

   // front end freezes on an interlock and for good once halted
   assign hold_front = stall_hold | halted;
   assign inst_addr  = pc[WORD_W-1:2];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc      <= TEXT_START;
         instr_d <= '0;
      end else if (!hold_front) begin
         pc      <= pc + 32'd4;
         instr_d <= inst;
      end
   end

   mips_decode u_decode (
      .instr    (instr_d),
      .src_rs   (src_rs),
      .src_rt   (src_rt),
      .dest_reg (dest_d),
      .reads_rt (reads_rt_d),
      .reg_we   (reg_we_d),
      .use_imm  (use_imm_d),
      .is_store (is_store_d),
      .is_load  (is_load_d),
      .is_sys   (is_sys_d),
      .alu_sel  (alu_sel_d),
      .ld_sel   (ld_sel_d),
      .st_sel   (st_sel_d),
      .mem_mask (mem_mask_d),
      .imm      (imm_d)
   );

   mips_hazard u_hazard (
      .clk        (clk),
      .rst_b      (rst_b),
      .src_rs     (src_rs),
      .src_rt     (src_rt),
      .reads_rt   (reads_rt_d),
      .dest_ex    (dest_ex),
      .dest_mem   (dest_mem),
      .dest_wb    (dest_wb),
      .we_ex      (reg_we_ex),
      .we_mem     (reg_we_mem),
      .we_wb      (reg_we_wb),
      .stall_hold (stall_hold)
   );

   mips_regfile u_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rd_a    (src_rs),
      .rd_b    (src_rt),
      .wr_addr (dest_wb),
      .wr_en   (reg_we_wb),
      .wr_data (wr_data),
      .rdata_a (rs_data_d),
      .rdata_b (rt_data_d)
   );

   // stage control, cleared at reset
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         reg_we_ex    <= 1'b0;
         use_imm_ex   <= 1'b0;
         is_store_ex  <= 1'b0;
         is_load_ex   <= 1'b0;
         is_sys_ex    <= 1'b0;
         alu_sel_ex   <= '0;
         ld_sel_ex    <= '0;
         st_sel_ex    <= '0;
         mem_mask_ex  <= '0;
         dest_ex      <= '0;
         reg_we_mem   <= 1'b0;
         is_store_mem <= 1'b0;
         is_load_mem  <= 1'b0;
         is_sys_mem   <= 1'b0;
         ld_sel_mem   <= '0;
         st_sel_mem   <= '0;
         mem_mask_mem <= '0;
         dest_mem     <= '0;
         reg_we_wb    <= 1'b0;
         is_load_wb   <= 1'b0;
         is_sys_wb    <= 1'b0;
         dest_wb      <= '0;
         halted       <= 1'b0;
      end else begin
         // a held decode sends a bubble into execute
         reg_we_ex    <= reg_we_d & ~stall_hold;
         is_store_ex  <= is_store_d & ~stall_hold;
         is_sys_ex    <= is_sys_d & ~stall_hold;
         use_imm_ex   <= use_imm_d;
         is_load_ex   <= is_load_d;
         alu_sel_ex   <= alu_sel_d;
         ld_sel_ex    <= ld_sel_d;
         st_sel_ex    <= st_sel_d;
         mem_mask_ex  <= mem_mask_d;
         dest_ex      <= dest_d;
         reg_we_mem   <= reg_we_ex;
         is_store_mem <= is_store_ex;
         is_load_mem  <= is_load_ex;
         is_sys_mem   <= is_sys_ex;
         ld_sel_mem   <= ld_sel_ex;
         st_sel_mem   <= st_sel_ex;
         mem_mask_mem <= mem_mask_ex;
         dest_mem     <= dest_ex;
         reg_we_wb    <= reg_we_mem;
         is_load_wb   <= is_load_mem;
         is_sys_wb    <= is_sys_mem;
         dest_wb      <= dest_mem;
         // sticky until reset
         halted       <= halted | is_sys_wb;
      end
   end

   // operand and result payload
   always_ff @(posedge clk) begin
      rs_data_ex <= rs_data_d;
      rt_data_ex <= rt_data_d;
      imm_ex     <= imm_d;
      alu_mem    <= alu_out;
      rt_mem     <= rt_data_ex;
      imm_hi_mem <= imm_ex[15:0];
      alu_wb     <= alu_mem;
      load_wb    <= load_data;
   end

   assign alu_b = use_imm_ex ? imm_ex : rt_data_ex;

   // shift amount rides in imm at the shamt position
   mips_alu u_alu (
      .op_a    (rs_data_ex),
      .op_b    (alu_b),
      .alu_sel (alu_sel_ex),
      .shamt   (imm_ex[10:6]),
      .result  (alu_out)
   );

   assign mem_addr = alu_mem[WORD_W-1:2];

   mips_mem_align u_mem_align (
      .addr_lo    (alu_mem[1:0]),
      .st_sel     (st_sel_mem),
      .mem_mask   (mem_mask_mem),
      .store_src  (rt_mem),
      .ld_sel     (ld_sel_mem),
      .mem_word   (mem_data_out),
      .imm_hi     (imm_hi_mem),
      .store_data (mem_data_in),
      .write_mask (write_mask),
      .load_data  (load_data)
   );

   // stores younger than a retiring syscall never reach memory
   assign mem_write_en = (halted || is_sys_wb) ? 4'b0000
                                               : (write_mask & {4{is_store_mem}});

   assign wr_data = is_load_wb ? load_wb : alu_wb;

endmodule

`default_nettype wire

// File: verification/mips_core_asserts.sv
// MIPS core bound assertions
`timescale 1ns/1ps
`default_nettype none

module mips_core_asserts (
   input logic        clk,
   input logic        rst_b,
   input logic [3:0]  mem_write_en,
   input logic        halted,
   input logic [31:0] pc
);

   // assertion failures so far
   int unsigned fail_count = 0;

   // no write strobe while in reset
   assert property (@(posedge clk) !rst_b |-> mem_write_en == 4'b0000)
      else begin
         fail_count++;
         $error("mem_write_en active during reset");
      end

   // halt is sticky
   assert property (@(posedge clk) disable iff (!rst_b) $past(halted) |-> halted)
      else begin
         fail_count++;
         $error("halted fell without reset");
      end

   // fetch stops once halted
   assert property (@(posedge clk) disable iff (!rst_b) halted && $past(halted) |-> $stable(pc))
      else begin
         fail_count++;
         $error("pc moved while halted");
      end

endmodule

bind mips_core mips_core_asserts u_asserts (
   .clk          (clk),
   .rst_b        (rst_b),
   .mem_write_en (mem_write_en),
   .halted       (halted),
   .pc           (pc)
);

`default_nettype wire

// File: verification/mips_core_tb.sv
// MIPS pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb;
   import mips_pkg::*;

   logic        clk = 1'b0;
   logic        rst_b;
   logic [31:0] inst, mem_data_out, mem_data_in;
   logic [29:0] inst_addr, mem_addr;
   logic [3:0]  mem_write_en;
   logic        halted;

   // instruction words and byte-lane data, both small and mirrored by the model
   logic [31:0] imem [256];
   logic [7:0]  dmem [1024];
   logic [31:0] m_regs [32];
   logic [7:0]  m_mem [1024];

   logic [31:0] all_instrs [$];
   logic [31:0] exp_addr [$], exp_mask [$], exp_data [$];
   int          split_at, errors = 0, unexpected = 0;
   logic [15:0] st_ptr;

   mips_core u_mips_core (
      .clk(clk), .rst_b(rst_b), .inst(inst), .mem_data_out(mem_data_out),
      .inst_addr(inst_addr), .mem_addr(mem_addr), .mem_data_in(mem_data_in),
      .mem_write_en(mem_write_en), .halted(halted)
   );

   always #2 clk = ~clk;

   // memories answer in the same cycle
   assign inst = imem[inst_addr[7:0]];
   assign mem_data_out = {dmem[{mem_addr[7:0], 2'd3}], dmem[{mem_addr[7:0], 2'd2}],
                          dmem[{mem_addr[7:0], 2'd1}], dmem[{mem_addr[7:0], 2'd0}]};

   always @(posedge clk) begin
      for (int l = 0; l < 4; l++) begin
         if (mem_write_en[l]) dmem[{mem_addr[7:0], l[1:0]}] <= mem_data_in[8*l +: 8];
      end
   end

   // fill pattern mixes both address bytes
   function automatic logic [7:0] fill_byte(input int i);
      return 8'((i * 37) ^ (i >> 8) ^ 8'h5a);
   endfunction

   function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rd,
                                         input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] sh);
      return {OP_SPECIAL, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
                                         input logic [4:0] rs, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic emit(input logic [31:0] w);
      all_instrs.push_back(w);
   endtask

   task automatic store_reg(input logic [4:0] r);
      emit(enc_i(OP_SW, r, 5'd0, st_ptr));
      st_ptr = st_ptr + 16'd4;
   endtask

   task automatic load_const(input logic [4:0] r, input logic [31:0] v);
      emit(enc_i(OP_LUI, r, 5'd0, v[31:16]));
      emit(enc_i(OP_ORI, r, r, v[15:0]));
   endtask

   // sequential interpretation, stops at the first syscall
   function automatic void model_program(input int lo, input int hi);
      logic [31:0] w, a, b, res, sx, zx, addr;
      logic [5:0]  op, fn;
      logic [4:0]  rs, rt, rd, sh;
      logic [9:0]  ix;
      logic        wr;
      for (int i = 0; i < 32; i++) m_regs[i] = 32'd0;
      for (int i = 0; i < 1024; i++) m_mem[i] = fill_byte(i);
      for (int k = lo; k < hi; k++) begin
         w = all_instrs[k];
         op = w[31:26];
         rs = w[25:21];
         rt = w[20:16];
         rd = w[15:11];
         sh = w[10:6];
         fn = w[5:0];
         a = m_regs[rs];
         b = m_regs[rt];
         sx = {{16{w[15]}}, w[15:0]};
         zx = {16'd0, w[15:0]};
         addr = a + sx;
         ix = addr[9:0];
         wr = 1'b1;
         res = 32'd0;
         if (op == OP_SPECIAL && fn == FN_SYSCALL) break;
         case (op)
            OP_SPECIAL: begin
               rt = rd;
               case (fn)
                  FN_ADD, FN_ADDU: res = a + b;
                  FN_SUB, FN_SUBU: res = a - b;
                  FN_AND:  res = a & b;
                  FN_OR:   res = a | b;
                  FN_XOR:  res = a ^ b;
                  FN_NOR:  res = ~(a | b);
                  FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                  FN_SLTU: res = {31'd0, a < b};
                  FN_SLL:  res = b << sh;
                  FN_SRL:  res = b >> sh;
                  FN_SRA:  res = $signed(b) >>> sh;
                  FN_SLLV: res = b << a[4:0];
                  FN_SRLV: res = b >> a[4:0];
                  FN_SRAV: res = $signed(b) >>> a[4:0];
                  default: wr = 1'b0;
               endcase
            end
            OP_ADDIU: res = a + sx;
            OP_SLTI:  res = {31'd0, $signed(a) < $signed(sx)};
            OP_SLTIU: res = {31'd0, a < sx};
            OP_ANDI:  res = a & zx;
            OP_ORI:   res = a | zx;
            OP_XORI:  res = a ^ zx;
            OP_LUI:   res = {w[15:0], 16'd0};
            OP_LB:    res = {{24{m_mem[ix][7]}}, m_mem[ix]};
            OP_LBU:   res = {24'd0, m_mem[ix]};
            OP_LH:    res = {{16{m_mem[ix+1][7]}}, m_mem[ix+1], m_mem[ix]};
            OP_LHU:   res = {16'd0, m_mem[ix+1], m_mem[ix]};
            OP_LW:    res = {m_mem[ix+3], m_mem[ix+2], m_mem[ix+1], m_mem[ix]};
            OP_SB, OP_SH, OP_SW: begin
               wr = 1'b0;
               exp_addr.push_back({2'b00, addr[31:2]});
               if (op == OP_SB) begin
                  exp_mask.push_back(32'h1 << addr[1:0]);
                  exp_data.push_back({24'd0, b[7:0]} << (8 * addr[1:0]));
                  m_mem[ix] = b[7:0];
               end else if (op == OP_SH) begin
                  exp_mask.push_back(32'h3 << addr[1:0]);
                  exp_data.push_back({16'd0, b[15:0]} << (8 * addr[1:0]));
                  m_mem[ix] = b[7:0];
                  m_mem[ix+1] = b[15:8];
               end else begin
                  exp_mask.push_back(32'hf);
                  exp_data.push_back(b);
                  for (int l = 0; l < 4; l++) m_mem[ix+l] = b[8*l +: 8];
               end
            end
            default: wr = 1'b0;
         endcase
         if (wr && rt != 5'd0) m_regs[rt] = res;
      end
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got %h expected %h", name, got, exp);
      end
   endtask

   // every store seen on the bus is matched against the next expected one
   always @(negedge clk) begin
      logic [31:0] lanes;
      if (rst_b && mem_write_en != 4'b0000) begin
         if (exp_addr.size() == 0) begin
            unexpected++;
            $display("store seen at word address %h with no expected store left", mem_addr);
         end else begin
            lanes = {{8{exp_mask[0][3]}}, {8{exp_mask[0][2]}},
                     {8{exp_mask[0][1]}}, {8{exp_mask[0][0]}}};
            check_value("mem_addr", {2'b00, mem_addr}, exp_addr.pop_front());
            check_value("mem_write_en", {28'd0, mem_write_en}, exp_mask.pop_front());
            check_value("mem_data_in", mem_data_in & lanes, exp_data.pop_front() & lanes);
         end
      end
   end

   task automatic build_programs();
      logic [5:0] r_fns [16];
      logic [5:0] i_ops [7];
      logic [5:0] l_ops [5];
      logic [15:0] imm, base;
      r_fns = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
      i_ops = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
      l_ops = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
      // program one: register ops, immediates, dependent chains
      st_ptr = 16'h0200;
      for (int r = 1; r <= 8; r++) load_const(5'(r), $urandom);
      foreach (r_fns[f]) begin
         emit(enc_r(r_fns[f], 5'd9, 5'(1 + $urandom % 8), 5'(1 + $urandom % 8), 5'($urandom)));
         store_reg(5'd9);
      end
      for (int pass = 0; pass < 2; pass++) begin
         foreach (i_ops[o]) begin
            imm = 16'($urandom);
            imm[15] = (pass == 0);
            emit(enc_i(i_ops[o], 5'd10, 5'(1 + $urandom % 8), imm));
            store_reg(5'd10);
         end
      end
      for (int d = 1; d <= 3; d++) begin
         emit(enc_i(OP_ADDIU, 5'd11, 5'd1, 16'($urandom)));
         for (int g = 1; g < d; g++) emit(enc_i(OP_ORI, 5'(20 + g), 5'd3, 16'($urandom)));
         emit(enc_r(FN_ADDU, 5'd13, 5'd11, 5'd2, 5'd0));
         store_reg(5'd13);
      end
      emit(enc_r(FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      store_reg(5'd1);
      split_at = all_instrs.size();
      // program two: loads of preloaded data, then narrow stores
      st_ptr = 16'h0200;
      foreach (l_ops[o]) begin
         for (int off = 0; off < 4; off++) begin
            base = 16'(($urandom % 64) * 4);
            if ((l_ops[o] == OP_LW && off == 0) || (l_ops[o] inside {OP_LH, OP_LHU} &&
                off % 2 == 0) || l_ops[o] inside {OP_LB, OP_LBU}) begin
               emit(enc_i(l_ops[o], 5'd14, 5'd0, base + 16'(off)));
               store_reg(5'd14);
            end
         end
      end
      load_const(5'd15, $urandom);
      for (int off = 0; off < 4; off++) emit(enc_i(OP_SB, 5'd15, 5'd0, 16'h0300 + 16'(off)));
      for (int off = 0; off < 4; off += 2) emit(enc_i(OP_SH, 5'd15, 5'd0, 16'h0310 + 16'(off)));
      emit(enc_i(OP_LW, 5'd16, 5'd0, 16'h0300));
      store_reg(5'd16);
      emit(enc_r(FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      emit(enc_i(OP_SB, 5'd15, 5'd0, 16'h0320));
   endtask

   task automatic run_program(input int lo, input int hi);
      @(posedge clk);
      rst_b <= 1'b0;
      for (int i = 0; i < 256; i++) imem[i] = (lo + i < hi) ? all_instrs[lo + i] : 32'd0;
      for (int i = 0; i < 1024; i++) dmem[i] = fill_byte(i);
      model_program(lo, hi);
      repeat (3) @(posedge clk);
      rst_b <= 1'b1;
      wait (halted === 1'b1);
      repeat (8) @(posedge clk);
      check_value("pending_stores", exp_addr.size(), 32'd0);
   endtask

   // watchdog sized from the number of instructions in all programs
   initial begin
      wait (split_at > 0);
      repeat (20 * all_instrs.size()) @(posedge clk);
      $display("watchdog expired before the programs halted");
      $display("Test failed");
      $finish;
   end

   initial begin
      // reset applies from time zero
      rst_b <= 1'b0;
      void'($urandom(40));
      for (int i = 0; i < 256; i++) imem[i] = 32'd0;
      for (int i = 0; i < 1024; i++) dmem[i] = 8'd0;
      build_programs();
      run_program(0, split_at);
      run_program(split_at, all_instrs.size());
      $display("errors: %0d, unexpected stores: %0d, assertion failures: %0d",
               errors, unexpected, u_mips_core.u_asserts.fail_count);
      if (errors == 0 && unexpected == 0 && u_mips_core.u_asserts.fail_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
rtl/mips_pkg.sv
rtl/mips_decode.sv
rtl/mips_hazard.sv
rtl/mips_regfile.sv
rtl/mips_alu.sv
rtl/mips_mem_align.sv
rtl/mips_core.sv
verification/mips_core_asserts.sv
verification/mips_core_tb.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - rtl/mips_pkg.sv
  - rtl/mips_decode.sv
  - rtl/mips_hazard.sv
  - rtl/mips_regfile.sv
  - rtl/mips_alu.sv
  - rtl/mips_mem_align.sv
  - rtl/mips_core.sv
  - target: simulation
    files:
      - verification/mips_core_asserts.sv
      - verification/mips_core_tb.sv
